/* hw/frontend_pkg.sv */
package frontend_pkg;

    localparam int block_slots = 4;
    localparam int slot_idx_w  = 2;
    localparam int fsq_idx_w   = 4;
    localparam int block_bytes = 16;
    localparam int ibuf_depth  = 16;
    localparam int ibuf_ptr_w  = $clog2(ibuf_depth);

    // one fetch block from the icache side, with the predictor's guess
    typedef struct packed {
        logic [31:0]                        start_addr;
        logic [fsq_idx_w-1:0]               fsq_idx;
        logic [block_slots-1:0]             en;
        logic                               pred_taken;
        logic [slot_idx_w-1:0]              pred_size;
        logic [31:0]                        pred_target;
        logic [block_slots-1:0][31:0]       insts;
    } fetch_block_t;

    typedef struct packed {
        logic        branch;
        logic        direct;
        logic [31:0] target;
    } pd_bundle_t;

    // corrected stream sent back to the fetch queue
    typedef struct packed {
        logic [fsq_idx_w-1:0]  fsq_idx;
        logic [31:0]           start_addr;
        logic                  taken;
        logic [slot_idx_w-1:0] size;
        logic [31:0]           target;
    } redirect_t;

    typedef struct packed {
        logic [31:0]          inst;
        logic [31:0]          pc;
        logic [fsq_idx_w-1:0] fsq_idx;
    } ibuf_entry_t;

endpackage

/* hw/pre_decoder.sv */
module pre_decoder (
    input  logic [31:0]             inst,
    input  logic [31:0]             addr,
    output frontend_pkg::pd_bundle_t bundle
);

    logic [6:0]  op;
    logic        is_jal;
    logic        is_jalr;
    logic        is_branch;
    logic [31:0] j_imm;

    assign op = inst[6:0];

    // major opcodes, low two bits must be 11 for a 32-bit encoding
    assign is_jal    = (op == 7'b1101111);
    assign is_jalr   = (op == 7'b1100111);
    assign is_branch = (op == 7'b1100011);

    // J-type immediate, bit 0 always zero
    assign j_imm = {
        {11{inst[31]}},
        inst[31],
        inst[19:12],
        inst[20],
        inst[30:21],
        1'b0
    };

    assign bundle.branch = is_jal | is_jalr | is_branch;
    assign bundle.direct = is_jal;
    // only meaningful when direct is set
    assign bundle.target = addr + j_imm;

endmodule

/* hw/pre_decode.sv */
module pre_decode (
    input  logic                                                      clk,
    input  logic                                                      rst,
    input  frontend_pkg::fetch_block_t                                block,
    input  logic                                                      block_valid,
    output logic                                                      block_ready,
    input  logic                                                      flush,
    input  logic                                                      ibuf_full,
    output frontend_pkg::redirect_t                                   redirect,
    output logic                                                      redirect_valid,
    output logic [frontend_pkg::block_slots-1:0]                      wr_en,
    output frontend_pkg::ibuf_entry_t [frontend_pkg::block_slots-1:0] wr_entries
);

    frontend_pkg::pd_bundle_t [frontend_pkg::block_slots-1:0] bundles;
    frontend_pkg::pd_bundle_t [frontend_pkg::block_slots-1:0] bundles_q;
    frontend_pkg::fetch_block_t                               block_q;
    logic                                                     valid_q;

    logic [frontend_pkg::block_slots-1:0] jal_mask;
    logic                                 has_jal;
    logic [frontend_pkg::slot_idx_w-1:0]  jal_idx;
    logic [frontend_pkg::slot_idx_w-1:0]  last_idx;
    logic [frontend_pkg::block_slots-1:0] jump_mask;
    logic                                 jump_error;
    logic                                 nobranch_error;
    logic                                 write_go;
    logic                                 accept;

    for (genvar i = 0; i < frontend_pkg::block_slots; i++) begin : g_pd
        pre_decoder pre_decoder_i (
            .inst   (block.insts[i]),
            .addr   (block.start_addr + 32'(4 * i)),
            .bundle (bundles[i])
        );
    end

    assign block_ready = ~ibuf_full & ~redirect_valid & ~flush;
    assign accept      = block_valid & block_ready;
    // block leaves the stage once the buffer has room
    assign write_go    = valid_q & ~ibuf_full;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (write_go) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            block_q   <= block;
            bundles_q <= bundles;
        end
    end

    // first enabled jal, and last enabled slot
    always_comb begin
        jal_idx  = '0;
        last_idx = '0;
        for (int i = frontend_pkg::block_slots - 1; i >= 0; i--) begin
            jal_mask[i] = block_q.en[i] & bundles_q[i].direct;
            if (jal_mask[i]) begin
                jal_idx = frontend_pkg::slot_idx_w'(i);
            end
        end
        for (int i = 0; i < frontend_pkg::block_slots; i++) begin
            if (block_q.en[i]) begin
                last_idx = frontend_pkg::slot_idx_w'(i);
            end
        end
    end

    assign has_jal = |jal_mask;

    assign jump_error = has_jal & (~block_q.pred_taken
                                   | (block_q.pred_size != jal_idx)
                                   | (block_q.pred_target != bundles_q[jal_idx].target));

    assign nobranch_error = ~has_jal & block_q.pred_taken
                            & (~block_q.en[block_q.pred_size]
                               | ~bundles_q[block_q.pred_size].branch);

    // held back while stalled, raised on the first cycle with room
    assign redirect_valid = write_go & ~flush & (jump_error | nobranch_error);

    assign redirect.fsq_idx    = block_q.fsq_idx;
    assign redirect.start_addr = block_q.start_addr;
    assign redirect.taken      = jump_error;
    assign redirect.size       = jump_error ? jal_idx : last_idx;
    assign redirect.target     = jump_error ? bundles_q[jal_idx].target
                                            : block_q.start_addr + 32'(frontend_pkg::block_bytes);

    always_comb begin
        for (int i = 0; i < frontend_pkg::block_slots; i++) begin
            jump_mask[i] = (frontend_pkg::slot_idx_w'(i) <= jal_idx);
        end
    end

    // truncate after the jal only when the jump was mispredicted
    assign wr_en = !write_go   ? '0 :
                   jump_error  ? (block_q.en & jump_mask) : block_q.en;

    for (genvar i = 0; i < frontend_pkg::block_slots; i++) begin : g_entry
        assign wr_entries[i].inst    = block_q.insts[i];
        assign wr_entries[i].pc      = block_q.start_addr + 32'(4 * i);
        assign wr_entries[i].fsq_idx = block_q.fsq_idx;
    end

endmodule

/* hw/inst_buffer.sv */
module inst_buffer (
    input  logic                                                      clk,
    input  logic                                                      rst,
    input  logic                                                      flush,
    input  logic [frontend_pkg::block_slots-1:0]                      wr_en,
    input  frontend_pkg::ibuf_entry_t [frontend_pkg::block_slots-1:0] wr_entries,
    output logic                                                      ibuf_full,
    output frontend_pkg::ibuf_entry_t                                 issue,
    output logic                                                      issue_valid,
    input  logic                                                      issue_ready
);

    frontend_pkg::ibuf_entry_t mem [frontend_pkg::ibuf_depth];

    logic [frontend_pkg::ibuf_ptr_w-1:0] wr_ptr;
    logic [frontend_pkg::ibuf_ptr_w-1:0] rd_ptr;
    logic [frontend_pkg::ibuf_ptr_w:0]   count;
    logic [frontend_pkg::ibuf_ptr_w-1:0] wr_addr [frontend_pkg::block_slots];
    logic [frontend_pkg::slot_idx_w:0]   wr_num;
    logic                                rd_go;

    // each masked slot lands after the ones before it
    always_comb begin
        wr_num = '0;
        for (int i = 0; i < frontend_pkg::block_slots; i++) begin
            wr_addr[i] = wr_ptr + frontend_pkg::ibuf_ptr_w'(wr_num);
            wr_num     = wr_num + (frontend_pkg::slot_idx_w + 1)'(wr_en[i]);
        end
    end

    assign issue_valid = (count != '0);
    assign issue       = mem[rd_ptr];
    assign rd_go       = issue_valid & issue_ready;

    // full when a whole block no longer fits
    assign ibuf_full = count > (frontend_pkg::ibuf_ptr_w + 1)'(frontend_pkg::ibuf_depth
                                                              - frontend_pkg::block_slots);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + frontend_pkg::ibuf_ptr_w'(wr_num);
            if (rd_go) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (frontend_pkg::ibuf_ptr_w + 1)'(wr_num)
                     - (frontend_pkg::ibuf_ptr_w + 1)'(rd_go);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < frontend_pkg::block_slots; i++) begin
            if (wr_en[i]) begin
                mem[wr_addr[i]] <= wr_entries[i];
            end
        end
    end

endmodule

/* hw/frontend_top.sv */
module frontend_top (
    input  logic                       clk,
    input  logic                       rst,
    input  frontend_pkg::fetch_block_t block,
    input  logic                       block_valid,
    output logic                       block_ready,
    input  logic                       flush,
    output frontend_pkg::redirect_t    redirect,
    output logic                       redirect_valid,
    output frontend_pkg::ibuf_entry_t  issue,
    output logic                       issue_valid,
    input  logic                       issue_ready
);

    logic                                                      ibuf_full;
    logic [frontend_pkg::block_slots-1:0]                      wr_en;
    frontend_pkg::ibuf_entry_t [frontend_pkg::block_slots-1:0] wr_entries;

    pre_decode pre_decode_i (
        .clk            (clk),
        .rst            (rst),
        .block          (block),
        .block_valid    (block_valid),
        .block_ready    (block_ready),
        .flush          (flush),
        .ibuf_full      (ibuf_full),
        .redirect       (redirect),
        .redirect_valid (redirect_valid),
        .wr_en          (wr_en),
        .wr_entries     (wr_entries)
    );

    inst_buffer inst_buffer_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .wr_en       (wr_en),
        .wr_entries  (wr_entries),
        .ibuf_full   (ibuf_full),
        .issue       (issue),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready)
    );

endmodule

/* verification/frontend_tb.sv */
module frontend_tb;

    localparam int n_tests      = 6;
    localparam int test_blocks  = 60;
    localparam int reset_cycles = 16;
    localparam int cycle_limit  = reset_cycles + 20 * n_tests * test_blocks;

    logic                       clk = 1'b0;
    logic                       rst;
    frontend_pkg::fetch_block_t block;
    logic                       block_valid;
    logic                       block_ready;
    logic                       flush;
    frontend_pkg::redirect_t    redirect;
    logic                       redirect_valid;
    frontend_pkg::ibuf_entry_t  issue;
    logic                       issue_valid;
    logic                       issue_ready;

    // expected stream, built from each accepted block
    frontend_pkg::ibuf_entry_t exp_q [$];
    frontend_pkg::redirect_t   exp_redir;
    logic                      exp_redir_pending = 1'b0;
    logic                      drop_block = 1'b0;
    logic                      full_seen;
    logic [3:0]                next_fsq = 4'd0;
    logic [31:0]               next_addr = 32'h0000_1000;
    int                        cycles = 0;
    int                        errors = 0;
    int                        checks = 0;
    int                        accepted;
    int                        redirects;

    frontend_top frontend_top_i (
        .clk            (clk),
        .rst            (rst),
        .block          (block),
        .block_valid    (block_valid),
        .block_ready    (block_ready),
        .flush          (flush),
        .redirect       (redirect),
        .redirect_valid (redirect_valid),
        .issue          (issue),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("run stopped after %0d cycles without finishing the tests", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic int mix_kind();
        int k;
        k = int'($urandom % 8);
        if (k < 4) begin
            return k % 2;
        end
        return (k == 4) ? 2 : (k == 5) ? 3 : 4;
    endfunction

    // 0/1 alu, 2 jal, 3 jalr, 4 conditional branch
    function automatic logic [31:0] rand_inst(input int kind);
        logic [31:0] r;
        r = $urandom;
        case (kind)
            0: return {r[31:7], 7'b0110011};
            1: return {r[31:7], 7'b0010011};
            2: return {r[31:7], 7'b1101111};
            3: return {r[31:7], 7'b1100111};
            default: return {r[31:7], 7'b1100011};
        endcase
    endfunction

    function automatic logic is_jal(input logic [31:0] inst);
        return inst[6:0] == 7'b1101111;
    endfunction

    function automatic logic is_cfi(input logic [31:0] inst);
        return inst[6:0] inside {7'b1101111, 7'b1100111, 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_dest(input logic [31:0] inst, input logic [31:0] pc);
        logic [20:0] imm;
        imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        return pc + {{11{imm[20]}}, imm};
    endfunction

    function automatic int first_jal(input frontend_pkg::fetch_block_t b);
        for (int i = 0; i < 4; i++) begin
            if (b.en[i] && is_jal(b.insts[i])) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // mode 0 correct, 1 false taken, 2 wrong jal, others half random
    task automatic make_block(input int mode);
        int n;
        int s;
        int j;
        n = 1 + int'($urandom % 4);
        s = int'($urandom % 4);
        block.start_addr = next_addr;
        block.fsq_idx    = next_fsq;
        next_fsq         = next_fsq + 4'd1;
        block.en         = 4'((1 << n) - 1);
        for (int i = 0; i < 4; i++) begin
            block.insts[i] = rand_inst(mix_kind());
        end
        block.pred_taken  = 1'($urandom);
        block.pred_size   = 2'($urandom);
        block.pred_target = $urandom;
        if (mode == 1) begin
            for (int i = 0; i < 4; i++) begin
                if (is_jal(block.insts[i])) begin
                    block.insts[i] = rand_inst(0);
                end
            end
            block.insts[s]   = rand_inst(1);
            block.pred_taken = 1'b1;
            block.pred_size  = 2'(s);
        end else if (mode == 2 || mode == 0 || $urandom % 2 == 0) begin
            if (mode == 2) begin
                block.insts[s % n] = rand_inst(2);
            end
            j = first_jal(block);
            if (j >= 0) begin
                block.pred_taken  = 1'b1;
                block.pred_size   = 2'(j);
                block.pred_target = jal_dest(block.insts[j], next_addr + 32'(4 * j));
            end else begin
                block.pred_size  = 2'(s);
                block.pred_taken = block.en[s] && is_cfi(block.insts[s]) && ($urandom % 2 == 1);
            end
            if (mode == 2) begin
                case ($urandom % 3)
                    0: block.pred_taken = 1'b0;
                    1: block.pred_size = 2'(j + 1 + int'($urandom % 3));
                    default: block.pred_target = block.pred_target + 32'h4;
                endcase
            end
        end
    endtask

    task automatic model_accept(input frontend_pkg::fetch_block_t b);
        int j;
        int last;
        logic jump_err;
        logic nb_err;
        logic [31:0] tgt;
        frontend_pkg::ibuf_entry_t e;
        j = first_jal(b);
        last = 0;
        for (int i = 0; i < 4; i++) begin
            if (b.en[i]) begin
                last = i;
            end
        end
        tgt = (j >= 0) ? jal_dest(b.insts[j], b.start_addr + 32'(4 * j)) : 32'h0;
        jump_err = (j >= 0)
                   && (!b.pred_taken || int'(b.pred_size) != j || b.pred_target != tgt);
        nb_err = (j < 0) && b.pred_taken
                 && !(b.en[b.pred_size] && is_cfi(b.insts[b.pred_size]));
        exp_redir_pending    = jump_err || nb_err;
        exp_redir.fsq_idx    = b.fsq_idx;
        exp_redir.start_addr = b.start_addr;
        exp_redir.taken      = jump_err;
        exp_redir.size       = jump_err ? 2'(j) : 2'(last);
        exp_redir.target     = jump_err ? tgt : b.start_addr + 32'd16;
        for (int i = 0; i < 4; i++) begin
            if (b.en[i] && (!jump_err || i <= j)) begin
                e.inst    = b.insts[i];
                e.pc      = b.start_addr + 32'(4 * i);
                e.fsq_idx = b.fsq_idx;
                exp_q.push_back(e);
            end
        end
    endtask

    // sampled in the low phase, where all DUT outputs are settled
    task automatic observe();
        frontend_pkg::ibuf_entry_t e;
        if (issue_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("issue_valid high at pc %h while no instruction was expected", issue.pc);
                errors++;
            end
        end
        if (issue_valid && issue_ready && exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check_val("issue.inst", issue.inst, e.inst);
            check_val("issue.pc", issue.pc, e.pc);
            check_val("issue.fsq_idx", 32'(issue.fsq_idx), 32'(e.fsq_idx));
        end
        if (redirect_valid) begin
            redirects++;
            assert (exp_redir_pending) else begin
                $display("redirect raised for fsq %h with a correct prediction", redirect.fsq_idx);
                errors++;
            end
            check_val("redirect.fsq_idx", 32'(redirect.fsq_idx), 32'(exp_redir.fsq_idx));
            check_val("redirect.start_addr", redirect.start_addr, exp_redir.start_addr);
            check_val("redirect.taken", 32'(redirect.taken), 32'(exp_redir.taken));
            check_val("redirect.size", 32'(redirect.size), 32'(exp_redir.size));
            check_val("redirect.target", redirect.target, exp_redir.target);
            exp_redir_pending = 1'b0;
            drop_block = 1'b1;
            next_addr = redirect.target;
        end
        if (block_valid && !block_ready && !redirect_valid && !flush) begin
            full_seen = 1'b1;
        end
        if (block_valid && block_ready) begin
            assert (!exp_redir_pending) else begin
                $display("a redirect was expected for fsq %h but never raised", exp_redir.fsq_idx);
                errors++;
            end
            model_accept(block);
            accepted++;
            drop_block = 1'b1;
            next_addr = block.start_addr + 32'd16;
        end
        if (flush) begin
            exp_q.delete();
            exp_redir_pending = 1'b0;
        end
    endtask

    task automatic run_cycle(input int mode, input logic offer, input int flush_pct);
        @(negedge clk);
        if (drop_block) begin
            block_valid = 1'b0;
            drop_block  = 1'b0;
        end
        if (!block_valid && offer && $urandom % 8 != 0) begin
            make_block(mode);
            block_valid = 1'b1;
        end
        flush = int'($urandom % 100) < flush_pct;
        if (mode == 4 && offer) begin
            issue_ready = (cycles % 48) >= 36;
        end else begin
            issue_ready = !flush && ($urandom % 5 != 0);
        end
        #1;
        observe();
    endtask

    task automatic run_test(input string name, input int mode, input int flush_pct);
        int c0;
        int e0;
        c0 = checks;
        e0 = errors;
        accepted  = 0;
        redirects = 0;
        full_seen = 1'b0;
        while (accepted < test_blocks) begin
            run_cycle(mode, 1'b1, flush_pct);
        end
        while (block_valid || exp_q.size() != 0 || exp_redir_pending) begin
            run_cycle(mode, 1'b0, 0);
        end
        if (mode == 1 || mode == 2) begin
            assert (redirects != 0) else begin
                $display("no redirect was raised for mispredicted blocks");
                errors++;
            end
        end
        if (mode == 4) begin
            assert (full_seen) else begin
                $display("block_ready never fell while the buffer was filling");
                errors++;
            end
        end
        $display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    initial begin
        void'($urandom(32'h54e2));
        rst         = 1'b1;
        block       = '0;
        block_valid = 1'b0;
        flush       = 1'b0;
        issue_ready = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_val("block_ready", 32'(block_ready), 32'h1);
        check_val("redirect_valid", 32'(redirect_valid), 32'h0);
        check_val("issue_valid", 32'(issue_valid), 32'h0);
        $display("test reset: %0d checks, %0d errors", checks, errors);
        run_test("order", 0, 0);
        run_test("false_taken", 1, 0);
        run_test("jal_mispredict", 2, 0);
        run_test("random_mix", 3, 0);
        run_test("back_pressure", 4, 0);
        run_test("flush", 5, 4);
        $display("all tests: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* src.f */
hw/frontend_pkg.sv
hw/pre_decoder.sv
hw/pre_decode.sv
hw/inst_buffer.sv
hw/frontend_top.sv
verification/frontend_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= frontend_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= src.f
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then exit 1; fi
	@grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
